// File: source/uart_tx_pkg.sv
////////////////////////////////////////////////////////////
// uart transmit definitions
// fifo geometry, lcr field positions, transmitter states
// and bit timing shared by the transmit path
////////////////////////////////////////////////////////////

package uart_tx_pkg;

  ////////////////////////////////////////////////////////////
  // fifo geometry
  ////////////////////////////////////////////////////////////
  localparam int FIFO_WIDTH     = 8;   // one byte per entry
  localparam int FIFO_DEPTH     = 16;
  localparam int FIFO_POINTER_W = 4;   // wraps at depth
  localparam int FIFO_COUNTER_W = 5;   // count can reach 16

  localparam int DIVISOR_W = 16;       // baud divisor width

  ////////////////////////////////////////////////////////////
  // line control register fields
  ////////////////////////////////////////////////////////////
  localparam int LC_BITS_LO = 0;  // word length, 5..8 bits
  localparam int LC_BITS_HI = 1;
  localparam int LC_SB      = 2;  // stop select
  localparam int LC_PE      = 3;  // parity enable
  localparam int LC_EP      = 4;  // even parity
  localparam int LC_SP      = 5;  // stick parity
  localparam int LC_BC      = 6;  // break control

  // transmitter fsm
  typedef enum logic [2:0] {
    TX_IDLE        = 3'd0,
    TX_SEND_START  = 3'd1,
    TX_SEND_BYTE   = 3'd2,
    TX_SEND_PARITY = 3'd3,
    TX_SEND_STOP   = 3'd4,
    TX_POP_BYTE    = 3'd5
  } tx_state_e;

  ////////////////////////////////////////////////////////////
  // bit timing, in 16x baud enables
  ////////////////////////////////////////////////////////////
  localparam int TICKS_PER_BIT = 16;
  localparam int STOP_TICKS_1  = 13;  // plus idle and pop states
  localparam int STOP_TICKS_15 = 21;  // 5 bit words only
  localparam int STOP_TICKS_2  = 29;

endpackage

// File: source/uart_tx_fifo.sv
////////////////////////////////////////////////////////////
// uart transmit fifo
// 16 x 8 circular buffer with fill count, sticky overrun,
// synchronous flush and status clear
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_tx_fifo (
  input  logic                                   clk,
  input  logic                                   wb_rst_i,
  input  logic                                   push_i,
  input  logic                                   pop_i,
  input  logic                                   fifo_reset_i,    // flush
  input  logic                                   reset_status_i,  // clears overrun
  input  logic [uart_tx_pkg::FIFO_WIDTH-1:0]     data_i,
  output logic [uart_tx_pkg::FIFO_WIDTH-1:0]     data_o,
  output logic [uart_tx_pkg::FIFO_COUNTER_W-1:0] count_o,
  output logic                                   overrun_o
);

  import uart_tx_pkg::*;

  logic [FIFO_WIDTH-1:0]     mem [FIFO_DEPTH];
  logic [FIFO_POINTER_W-1:0] wr_ptr;  // next free slot
  logic [FIFO_POINTER_W-1:0] rd_ptr;  // head entry
  logic                      full;
  logic                      empty;
  logic                      do_push;
  logic                      do_pop;

  assign full    = (count_o == FIFO_COUNTER_W'(FIFO_DEPTH));
  assign empty   = (count_o == '0);
  assign do_pop  = pop_i & ~empty;
  assign do_push = push_i & (~full | do_pop);  // a pop frees the slot

  assign data_o = mem[rd_ptr];  // head shown without a read cycle

  // storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  ////////////////////////////////////////////////////////////
  // pointers and fill level
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else if (fifo_reset_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // natural wrap at 16
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;  // none or both
      endcase
    end
  end

  // overrun stays set until software clears it
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      overrun_o <= 1'b0;
    end else if (fifo_reset_i | reset_status_i) begin
      overrun_o <= 1'b0;
    end else if (push_i & ~do_push) begin
      overrun_o <= 1'b1;  // byte dropped
    end
  end

  // transmitter must only pop a byte it saw queued
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (wb_rst_i) pop_i |-> !empty
  ) else $error("tx fifo popped while empty");

  a_count_bound: assert property (
    @(posedge clk) disable iff (wb_rst_i)
    count_o <= FIFO_COUNTER_W'(FIFO_DEPTH)
  ) else $error("tx fifo count above depth");

endmodule

// File: source/uart_baud_gen.sv
////////////////////////////////////////////////////////////
// uart baud generator
// divisor down-counter giving a one-cycle 16x enable strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_baud_gen (
  input  logic                              clk,
  input  logic                              wb_rst_i,
  input  logic [uart_tx_pkg::DIVISOR_W-1:0] divisor_i,
  output logic                              enable_o
);

  import uart_tx_pkg::*;

  logic [DIVISOR_W-1:0] dl_cnt;  // clocks left to next strobe

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      dl_cnt   <= '0;
      enable_o <= 1'b0;
    end else if (divisor_i == '0) begin
      dl_cnt   <= '0;  // stopped, restarts at once on a new divisor
      enable_o <= 1'b0;
    end else if (dl_cnt <= DIVISOR_W'(1)) begin
      dl_cnt   <= divisor_i;  // new divisor picked up here
      enable_o <= 1'b1;
    end else begin
      dl_cnt   <= dl_cnt - 1'b1;
      enable_o <= 1'b0;
    end
  end

  // a strobe needs a running divisor in the cycle before
  a_no_enable_stopped: assert property (
    @(posedge clk) disable iff (wb_rst_i)
    $rose(enable_o) |-> ($past(divisor_i) != '0)
  ) else $error("baud enable rose with divisor 0");

endmodule

// File: source/uart_transmitter.sv
////////////////////////////////////////////////////////////
// uart transmitter
// pops bytes from the tx fifo and sends them lsb first with
// start bit, optional parity and 1, 1.5 or 2 stop bits;
// break forces the line low
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_transmitter (
  input  logic                                   clk,
  input  logic                                   wb_rst_i,
  input  logic                                   enable_i,    // 16x baud strobe
  input  logic                                   tf_push_i,
  input  logic                                   tx_reset_i,  // fifo flush
  input  logic                                   lsr_mask_i,  // overrun clear
  input  logic [7:0]                             lcr_i,
  input  logic [uart_tx_pkg::FIFO_WIDTH-1:0]     wb_dat_i,
  output logic                                   stx_pad_o,
  output uart_tx_pkg::tx_state_e                 tstate_o,
  output logic [uart_tx_pkg::FIFO_COUNTER_W-1:0] tf_count_o,
  output logic                                   tf_overrun_o
);

  import uart_tx_pkg::*;

  logic [4:0]            counter;      // ticks left in current bit
  logic [2:0]            bit_counter;  // data bits still to send
  logic [6:0]            shift_out;
  logic                  bit_out;      // bit on its way to the line
  logic                  parity_xor;
  logic                  stx_o_tmp;    // line before break gating
  logic                  tf_pop;
  logic [FIFO_WIDTH-1:0] tf_data_out;  // fifo head
  logic [1:0]            word_len;
  logic [FIFO_WIDTH-1:0] word_mask;

  uart_tx_fifo uart_tx_fifo_inst (
    .clk            (clk),
    .wb_rst_i       (wb_rst_i),
    .push_i         (tf_push_i),
    .pop_i          (tf_pop),
    .fifo_reset_i   (tx_reset_i),
    .reset_status_i (lsr_mask_i),
    .data_i         (wb_dat_i),
    .data_o         (tf_data_out),
    .count_o        (tf_count_o),
    .overrun_o      (tf_overrun_o)
  );

  assign word_len  = lcr_i[LC_BITS_HI:LC_BITS_LO];
  assign word_mask = 8'hff >> (2'd3 - word_len);  // 5 bits -> 8'h1f

  ////////////////////////////////////////////////////////////
  // frame fsm, steps on baud enables only
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      tstate_o    <= TX_IDLE;
      stx_o_tmp   <= 1'b1;  // line idles high
      counter     <= '0;
      bit_counter <= '0;
      shift_out   <= '0;
      bit_out     <= 1'b0;
      parity_xor  <= 1'b0;
      tf_pop      <= 1'b0;
    end else if (enable_i) begin
      unique case (tstate_o)
        TX_IDLE: begin
          stx_o_tmp <= 1'b1;
          if (tf_count_o != '0) tstate_o <= TX_POP_BYTE;
        end
        TX_POP_BYTE: begin
          tf_pop                 <= 1'b1;  // head already latched below
          bit_counter            <= 3'd4 + 3'(word_len);
          parity_xor             <= ^(tf_data_out & word_mask);
          {shift_out, bit_out}   <= tf_data_out;
          tstate_o               <= TX_SEND_START;
        end
        TX_SEND_START: begin
          tf_pop <= 1'b0;
          if (counter == '0) begin
            counter <= 5'(TICKS_PER_BIT - 1);
          end else if (counter == 5'd1) begin
            counter  <= '0;
            tstate_o <= TX_SEND_BYTE;
          end else begin
            counter <= counter - 1'b1;
          end
          stx_o_tmp <= 1'b0;
        end
        TX_SEND_BYTE: begin
          if (counter == '0) begin
            counter <= 5'(TICKS_PER_BIT - 1);
          end else if (counter == 5'd1) begin
            counter <= '0;
            if (bit_counter != '0) begin
              bit_counter <= bit_counter - 1'b1;
              bit_out     <= shift_out[0];  // next bit, lsb first
              shift_out   <= shift_out >> 1;
            end else if (!lcr_i[LC_PE]) begin
              tstate_o <= TX_SEND_STOP;  // no parity
            end else begin
              case ({lcr_i[LC_EP], lcr_i[LC_SP]})
                2'b00: bit_out <= ~parity_xor;  // odd
                2'b01: bit_out <= 1'b1;         // stick 1
                2'b10: bit_out <= parity_xor;   // even
                2'b11: bit_out <= 1'b0;         // stick 0
              endcase
              tstate_o <= TX_SEND_PARITY;
            end
          end else begin
            counter <= counter - 1'b1;
          end
          stx_o_tmp <= bit_out;
        end
        TX_SEND_PARITY: begin
          if (counter == '0) begin
            counter <= 5'(TICKS_PER_BIT - 1);
          end else if (counter == 5'd1) begin
            counter  <= '0;
            tstate_o <= TX_SEND_STOP;
          end else begin
            counter <= counter - 1'b1;
          end
          stx_o_tmp <= bit_out;
        end
        TX_SEND_STOP: begin
          if (counter == '0) begin
            if (!lcr_i[LC_SB]) counter <= 5'(STOP_TICKS_1);
            else if (word_len == 2'b00) counter <= 5'(STOP_TICKS_15);
            else counter <= 5'(STOP_TICKS_2);
          end else if (counter == 5'd1) begin
            counter  <= '0;
            tstate_o <= TX_IDLE;
          end else begin
            counter <= counter - 1'b1;
          end
          stx_o_tmp <= 1'b1;
        end
        default: tstate_o <= TX_IDLE;
      endcase
    end else begin
      tf_pop <= 1'b0;  // drop pop between enables
    end
  end

  // break wins at once, fsm keeps running underneath
  assign stx_pad_o = lcr_i[LC_BC] ? 1'b0 : stx_o_tmp;

  a_pop_single: assert property (
    @(posedge clk) disable iff (wb_rst_i) tf_pop |=> !tf_pop
  ) else $error("tx pop wider than one cycle");

  a_state_legal: assert property (
    @(posedge clk) disable iff (wb_rst_i)
    tstate_o inside {TX_IDLE, TX_SEND_START, TX_SEND_BYTE,
                     TX_SEND_PARITY, TX_SEND_STOP, TX_POP_BYTE}
  ) else $error("tx state out of range");

endmodule

// File: source/uart_tx_top.sv
////////////////////////////////////////////////////////////
// uart transmit top
// baud generator feeding the transmitter and its fifo
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_tx_top (
  input  logic                                   clk,
  input  logic                                   wb_rst_i,
  input  logic                                   tf_push_i,   // one byte per cycle
  input  logic                                   tx_reset_i,
  input  logic                                   lsr_mask_i,
  input  logic [7:0]                             lcr_i,
  input  logic [uart_tx_pkg::DIVISOR_W-1:0]      divisor_i,
  input  logic [uart_tx_pkg::FIFO_WIDTH-1:0]     wb_dat_i,
  output logic                                   stx_pad_o,
  output uart_tx_pkg::tx_state_e                 tstate_o,
  output logic [uart_tx_pkg::FIFO_COUNTER_W-1:0] tf_count_o,
  output logic                                   tf_overrun_o
);

  logic baud_enable;  // 16x strobe

  ////////////////////////////////////////////////////////////
  // baud rate
  ////////////////////////////////////////////////////////////
  uart_baud_gen uart_baud_gen_inst (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .divisor_i (divisor_i),
    .enable_o  (baud_enable)
  );

  ////////////////////////////////////////////////////////////
  // framing and fifo
  ////////////////////////////////////////////////////////////
  uart_transmitter uart_transmitter_inst (
    .clk          (clk),
    .wb_rst_i     (wb_rst_i),
    .enable_i     (baud_enable),
    .tf_push_i    (tf_push_i),
    .tx_reset_i   (tx_reset_i),
    .lsr_mask_i   (lsr_mask_i),
    .lcr_i        (lcr_i),
    .wb_dat_i     (wb_dat_i),
    .stx_pad_o    (stx_pad_o),
    .tstate_o     (tstate_o),
    .tf_count_o   (tf_count_o),
    .tf_overrun_o (tf_overrun_o)
  );

endmodule

// File: testbench/uart_tx_tb.sv
////////////////////////////////////////////////////////////
// uart transmit testbench
// drives bytes into the tx fifo, decodes the serial line
// and checks frames, fifo status and break
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module uart_tx_tb;

  import uart_tx_pkg::*;

  localparam int CLK_HALF   = 20;                   // 40 ns period
  localparam int DIV_FRAME  = 2;
  localparam int BIT_CLKS   = TICKS_PER_BIT * DIV_FRAME;
  localparam int N_FRAMES   = 8 + 12 + 2;           // tests 2, 3 and 4
  localparam int WDOG_CLKS  = N_FRAMES * 12 * BIT_CLKS * 3 / 2;

  logic        clk;
  logic        wb_rst_i;
  logic        tf_push_i;
  logic        tx_reset_i;
  logic        lsr_mask_i;
  logic [7:0]  lcr_i;
  logic [15:0] divisor_i;
  logic [7:0]  wb_dat_i;
  logic        stx_pad_o;
  tx_state_e   tstate_o;
  logic [4:0]  tf_count_o;
  logic        tf_overrun_o;

  // shared check strobe, looked at by the assertion below
  logic        chk_en;
  string       chk_name;
  logic [31:0] chk_got;
  logic [31:0] chk_exp;

  int          fail_count;
  int          check_count;
  int          test_count;
  int          test_fails;
  logic [15:0] lfsr;
  logic [7:0]  exp_q [$];  // bytes still on their way, masked

  uart_tx_top uart_tx_top_inst (
    .clk          (clk),
    .wb_rst_i     (wb_rst_i),
    .tf_push_i    (tf_push_i),
    .tx_reset_i   (tx_reset_i),
    .lsr_mask_i   (lsr_mask_i),
    .lcr_i        (lcr_i),
    .divisor_i    (divisor_i),
    .wb_dat_i     (wb_dat_i),
    .stx_pad_o    (stx_pad_o),
    .tstate_o     (tstate_o),
    .tf_count_o   (tf_count_o),
    .tf_overrun_o (tf_overrun_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  a_value_match: assert property (@(posedge clk) chk_en |-> (chk_got == chk_exp))
    else begin
      $display("** Error: %s = %h, expected %h", chk_name, chk_got, chk_exp);
      fail_count++;
    end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b[i] = lfsr[0];  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // called at a falling edge, checked on the next rising one
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_name = name;
    chk_got  = got;
    chk_exp  = exp;
    chk_en   = 1'b1;
    check_count++;
    @(negedge clk);
    chk_en = 1'b0;
  endtask

  // low bits of a word, word length is 5 plus lcr[1:0]
  function automatic logic [7:0] word_mask(input logic [7:0] lcr);
    int wlen;
    wlen = 5 + lcr[1:0];
    return 8'((1 << wlen) - 1);
  endfunction

  // parity bit as the lcr asks for it
  function automatic logic parity_rule(input logic [7:0] d, input logic [7:0] lcr);
    logic x;
    x = ^(d & word_mask(lcr));
    if (lcr[LC_SP]) return ~lcr[LC_EP];  // stick 1 or stick 0
    return lcr[LC_EP] ? x : ~x;
  endfunction

  task automatic push_bytes(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      rand_byte(b);
      @(negedge clk);
      wb_dat_i  = b;
      tf_push_i = 1'b1;
      exp_q.push_back(b & word_mask(lcr_i));
    end
    @(negedge clk);
    tf_push_i = 1'b0;
  endtask

  // samples each bit at its middle, bit time is BIT_CLKS
  task automatic decode_frames(input int n);
    logic [7:0] data;
    logic [7:0] exp;
    int         wlen;
    for (int f = 0; f < n; f++) begin
      @(negedge stx_pad_o);
      wlen = 5 + lcr_i[1:0];
      data = '0;
      repeat (BIT_CLKS / 2) @(negedge clk);
      check_value("stx_pad_o start", stx_pad_o, 0);
      repeat (BIT_CLKS - 1) @(negedge clk);  // check took a cycle
      for (int i = 0; i < wlen; i++) begin
        data[i] = stx_pad_o;  // lsb first
        if (i < wlen - 1) repeat (BIT_CLKS) @(negedge clk);
      end
      exp = exp_q.pop_front();
      check_value("rx data", data, exp);
      repeat (BIT_CLKS - 1) @(negedge clk);
      if (lcr_i[LC_PE]) begin
        check_value("rx parity", stx_pad_o, parity_rule(exp, lcr_i));
        repeat (BIT_CLKS - 1) @(negedge clk);
      end
      check_value("stx_pad_o stop", stx_pad_o, 1);
      if (lcr_i[LC_SB]) begin
        repeat (BIT_CLKS - 1) @(negedge clk);  // 1.5 bits into stop
        check_value("stx_pad_o stop 1.5", stx_pad_o, 1);
      end
    end
  endtask

  task automatic send_and_check(input int n);
    fork
      push_bytes(n);
      decode_frames(n);
    join
  endtask

  task automatic end_test(input string name);
    @(negedge clk);  // let the last assertion report
    test_count++;
    if (fail_count != test_fails) $display("test %s: FAIL", name);
    else $display("test %s: ok", name);
    test_fails = fail_count;
  endtask

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    repeat (WDOG_CLKS) @(posedge clk);
    $display("timeout: the transmitter did not finish all frames in time");
    $display("sim failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    wb_rst_i    = 1'b1;
    tf_push_i   = 1'b0;
    tx_reset_i  = 1'b0;
    lsr_mask_i  = 1'b0;
    lcr_i       = 8'h03;  // 8n1
    divisor_i   = 16'(DIV_FRAME);
    wb_dat_i    = '0;
    chk_en      = 1'b0;
    chk_name    = "";
    chk_got     = '0;
    chk_exp     = '0;
    fail_count  = 0;
    check_count = 0;
    test_count  = 0;
    test_fails  = 0;
    lfsr        = 16'd44626;
    repeat (10) @(negedge clk);
    wb_rst_i = 1'b0;

    // 1. reset values
    check_value("stx_pad_o", stx_pad_o, 1);
    check_value("tstate_o", tstate_o, TX_IDLE);
    check_value("tf_count_o", tf_count_o, 0);
    check_value("tf_overrun_o", tf_overrun_o, 0);
    end_test("1 reset");

    // 2. eight bytes 8n1
    send_and_check(8);
    check_value("tf_count_o", tf_count_o, 0);
    end_test("2 8n1 back to back");

    // 3. 5..7 bits with odd, even, stick 1, stick 0
    for (int w = 0; w < 3; w++) begin
      for (int p = 0; p < 4; p++) begin
        lcr_i = 8'(w) | 8'h08 | 8'(p << 4);  // pe set, ep and sp from p
        send_and_check(1);
      end
    end
    end_test("3 word length and parity");

    // 4. two stop bits, 8 bits no parity
    lcr_i = 8'h07;
    send_and_check(2);
    end_test("4 two stop bits");

    // 5. stopped baud, fill to overrun
    lcr_i     = 8'h03;
    divisor_i = '0;
    push_bytes(17);
    check_value("tf_count_o", tf_count_o, 16);
    check_value("tf_overrun_o", tf_overrun_o, 1);
    lsr_mask_i = 1'b1;
    @(negedge clk);
    lsr_mask_i = 1'b0;
    check_value("tf_overrun_o", tf_overrun_o, 0);
    tx_reset_i = 1'b1;
    @(negedge clk);
    tx_reset_i = 1'b0;
    check_value("tf_count_o", tf_count_o, 0);
    exp_q.delete();
    divisor_i = 16'(DIV_FRAME);
    end_test("5 fifo full and overrun");

    // 6. break, transmitter idle
    lcr_i[LC_BC] = 1'b1;
    @(negedge clk);
    check_value("stx_pad_o break", stx_pad_o, 0);
    lcr_i[LC_BC] = 1'b0;
    @(negedge clk);
    check_value("stx_pad_o idle", stx_pad_o, 1);
    end_test("6 break");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: project.f
source/uart_tx_pkg.sv
source/uart_tx_fifo.sv
source/uart_baud_gen.sv
source/uart_transmitter.sv
source/uart_tx_top.sv
testbench/uart_tx_tb.sv

// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert -j 0 -Mdir obj_dir
TOP   = uart_tx_tb
FLIST = project.f

.PHONY: sim clean

# pass only if the testbench prints its pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir
